// ==== Bender.yml ====
package:
  name: cnn_accel

export_include_dirs:
  - include

sources:
  - files:
      - rtl/cnn_arith_pkg.sv
      - rtl/cnn_cfg_pkg.sv
      - rtl/cnn_cfg_if.sv
      - rtl/ahb_cfg_regs.sv
      - rtl/frame_scan.sv
      - rtl/window_fetch.sv
      - rtl/conv_mac.sv
      - rtl/post_proc.sv
      - rtl/cnn_accel.sv
  - target: test
    files:
      - testbench/tb_cnn_accel.sv

// ==== include/cnn_accel_settings.svh ====
`ifndef CNN_ACCEL_SETTINGS_SVH
`define CNN_ACCEL_SETTINGS_SVH

// ----------------------------------------
// Frame and datapath sizes
// ----------------------------------------
`define CNN_MAX_DIM 16
`define CNN_N_CH 4
`define CNN_TAPS 9
`define CNN_KSIDE 3
`define CNN_PIX_W 8
`define CNN_WGT_W 8
`define CNN_PARAM_W 16
// 9 taps of 9x8 bit products
`define CNN_SUM_W 20
// Scaled sum plus a bias shifted by up to 31
`define CNN_ACC_W 48

// ----------------------------------------
// AHB side
// ----------------------------------------
`define CNN_HADDR_W 32
`define CNN_HDATA_W 32
// Register index starts at byte address bit 2, image word index above it
`define CNN_REG_LSB 2
`define CNN_IMG_LSB 6

`endif

// ==== list.f ====
+incdir+include
rtl/cnn_arith_pkg.sv
rtl/cnn_cfg_pkg.sv
rtl/cnn_cfg_if.sv
rtl/ahb_cfg_regs.sv
rtl/frame_scan.sv
rtl/window_fetch.sv
rtl/conv_mac.sv
rtl/post_proc.sv
rtl/cnn_accel.sv
testbench/tb_cnn_accel.sv

// ==== rtl/ahb_cfg_regs.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module ahb_cfg_regs (
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    HSEL_i,
	input  logic                    HREADY_i,
	input  logic [1:0]              HTRANS_i,
	input  logic [`CNN_HADDR_W-1:0] HADDR_i,
	input  logic                    HWRITE_i,
	input  logic [`CNN_HDATA_W-1:0] HWDATA_i,
	output logic                    HREADYOUT_o,
	output logic                    HRESP_o,
	output logic [`CNN_HDATA_W-1:0] HRDATA_o,
	cnn_cfg_if.regs                 cfg,
	input  logic                    busy_i,
	input  logic                    frame_done_i,
	output logic                    img_we_o,
	output cnn_cfg_pkg::img_addr_t  img_waddr_o,
	output logic [`CNN_HDATA_W-1:0] img_wdata_o
);
	import cnn_cfg_pkg::*;
	import cnn_arith_pkg::*;

	logic          xfer_ok;
	logic          wr_q;		// Write pending in data phase
	cnn_reg_e      reg_idx_q;
	img_addr_t     img_idx_q;
	logic          start_q;
	logic          done_q;
	cnn_reg_word_u wdata_u;
	cnn_reg_word_u rdata_u;

	// ----------------------------------------
	// Address phase
	// ----------------------------------------
	assign xfer_ok = HSEL_i && HREADY_i && (HTRANS_i == TRANS_NONSEQ || HTRANS_i == TRANS_SEQ);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			wr_q      <= 1'b0;
			reg_idx_q <= REG_DIMS;
			img_idx_q <= '0;
		end else if (xfer_ok) begin
			wr_q      <= HWRITE_i;
			reg_idx_q <= cnn_reg_e'(HADDR_i[`CNN_REG_LSB +: $bits(cnn_reg_e)]);
			img_idx_q <= HADDR_i[`CNN_IMG_LSB +: $bits(img_addr_t)];
		end else begin
			wr_q <= 1'b0;	// Idle or busy transfer
		end
	end

	// ----------------------------------------
	// Data phase, register file
	// ----------------------------------------
	assign wdata_u.raw = HWDATA_i;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			cfg.width      <= RST_DIM;
			cfg.height     <= RST_DIM;
			cfg.act_type   <= ACT_RELU;
			cfg.bias_shift <= RST_BIAS_SHIFT;
			cfg.act_shift  <= RST_ACT_SHIFT;
			start_q        <= 1'b0;
			done_q         <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (frame_done_i)
				done_q <= 1'b1;		// Last pixel left the pipeline
			if (wr_q) begin
				case (reg_idx_q)
					REG_DIMS: begin
						cfg.width  <= wdata_u.dims.width;
						cfg.height <= wdata_u.dims.height;
					end
					REG_LAYER: begin
						cfg.act_type   <= wdata_u.layer.act_type;
						cfg.bias_shift <= wdata_u.layer.bias_shift;
						cfg.act_shift  <= wdata_u.layer.act_shift;
					end
					REG_START: begin
						if (wdata_u.raw[0] && !busy_i && !start_q) begin	// Ignored while busy
							start_q <= 1'b1;
							done_q  <= 1'b0;
						end
					end
					REG_DONE: begin
						if (!wdata_u.raw[0])
							done_q <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	// Read-back from the registered address
	always_comb begin
		rdata_u.raw = '0;
		case (reg_idx_q)
			REG_DIMS: begin
				rdata_u.dims.width  = cfg.width;
				rdata_u.dims.height = cfg.height;
			end
			REG_LAYER: begin
				rdata_u.layer.act_type   = cfg.act_type;
				rdata_u.layer.bias_shift = cfg.bias_shift;
				rdata_u.layer.act_shift  = cfg.act_shift;
			end
			REG_START: rdata_u.raw[0] = busy_i | start_q;
			REG_DONE:  rdata_u.raw[0] = done_q;
			default: ;
		endcase
	end

	assign HRDATA_o    = rdata_u.raw;
	assign HREADYOUT_o = 1'b1;		// No wait states
	assign HRESP_o     = RESP_OKAY;
	assign cfg.start   = start_q;
	assign img_we_o    = wr_q && (reg_idx_q == REG_IMAGE);
	assign img_waddr_o = img_idx_q;
	assign img_wdata_o = HWDATA_i;

	a_htrans_known: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HSEL_i |-> !$isunknown(HTRANS_i));

endmodule

// ==== rtl/cnn_accel.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module cnn_accel (
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    HSEL_i,
	input  logic                    HREADY_i,
	input  logic [1:0]              HTRANS_i,
	input  logic [`CNN_HADDR_W-1:0] HADDR_i,
	input  logic                    HWRITE_i,
	input  logic [`CNN_HDATA_W-1:0] HWDATA_i,
	output logic                    HREADYOUT_o,
	output logic                    HRESP_o,
	output logic [`CNN_HDATA_W-1:0] HRDATA_o,
	output logic [`CNN_HDATA_W-1:0] out_pixel_o,
	output logic                    out_valid_o
);
	import cnn_cfg_pkg::*;
	import cnn_arith_pkg::*;

	cnn_cfg_if u_cfg_if ();

	logic                    busy;
	logic                    frame_done;
	logic                    img_we;
	img_addr_t               img_waddr;
	logic [`CNN_HDATA_W-1:0] img_wdata;
	pos_t                    row;
	pos_t                    col;
	logic                    pos_valid;
	logic                    pos_last;
	window_t                 win;
	logic                    win_valid;
	logic                    win_last;
	sum_vec_t                sum;
	logic                    sum_valid;
	logic                    sum_last;

	// ----------------------------------------
	// AHB slave and registers
	// ----------------------------------------
	ahb_cfg_regs u_regs (.*, .cfg(u_cfg_if.regs), .busy_i(busy), .frame_done_i(frame_done),
		.img_we_o(img_we), .img_waddr_o(img_waddr), .img_wdata_o(img_wdata));

	// ----------------------------------------
	// Pixel pipeline
	// ----------------------------------------
	frame_scan u_scan (.HCLK, .HRESETn, .cfg(u_cfg_if.scan), .busy_o(busy),
		.row_o(row), .col_o(col), .pos_valid_o(pos_valid), .pos_last_o(pos_last));

	window_fetch u_fetch (.HCLK, .HRESETn, .cfg(u_cfg_if.fetch),
		.img_we_i(img_we), .img_waddr_i(img_waddr), .img_wdata_i(img_wdata),
		.row_i(row), .col_i(col), .pos_valid_i(pos_valid), .pos_last_i(pos_last),
		.win_o(win), .win_valid_o(win_valid), .win_last_o(win_last));

	conv_mac u_mac (.HCLK, .HRESETn, .win_i(win), .win_valid_i(win_valid),
		.win_last_i(win_last), .sum_o(sum), .sum_valid_o(sum_valid), .sum_last_o(sum_last));

	post_proc u_post (.HCLK, .HRESETn, .cfg(u_cfg_if.post), .sum_i(sum),
		.sum_valid_i(sum_valid), .sum_last_i(sum_last), .out_pixel_o, .out_valid_o,
		.frame_done_o(frame_done));

endmodule

// ==== rtl/cnn_arith_pkg.sv ====
`include "cnn_accel_settings.svh"

package cnn_arith_pkg;

	typedef enum logic {ACT_RELU = 1'b0, ACT_LINEAR = 1'b1} act_type_e;

	// ----------------------------------------
	// Datapath words
	// ----------------------------------------
	typedef logic [`CNN_PIX_W-1:0]                    pixel_t;	// Unsigned
	typedef logic signed [`CNN_WGT_W-1:0]             weight_t;
	typedef logic signed [`CNN_PARAM_W-1:0]           param_t;	// Scale or bias
	typedef logic signed [`CNN_PIX_W+`CNN_WGT_W:0]    prod_t;	// Pixel zero-extended times weight
	typedef logic signed [`CNN_SUM_W-1:0]             sum_t;
	typedef logic signed [`CNN_ACC_W-1:0]             acc_t;

	typedef pixel_t  [0:`CNN_TAPS-1] window_t;	// Tap 0 top-left, row-major
	typedef weight_t [0:`CNN_TAPS-1] kern_t;
	typedef sum_t    [0:`CNN_N_CH-1] sum_vec_t;

	// ----------------------------------------
	// First-layer kernel
	// ----------------------------------------
	localparam kern_t KERN_W [`CNN_N_CH] = '{
		'{-114, -105, -41,  127,  -93, -51, -27,  -1, 113},
		'{  69,  -75, -47,   19, -128,  95, -35, 121,   8},
		'{  13,  -12,  -1,  -15,  127, -16,  -4, -19,   1},
		'{  69, -121, -21, -128,   32,  90,  48,  52, -45}
	};

	// Batch-norm style scale, then bias before shifting
	localparam param_t KERN_SCALE [`CNN_N_CH] = '{16'sd95, 16'sd103, 16'sd364, 16'sd170};
	localparam param_t KERN_BIAS  [`CNN_N_CH] = '{-16'sd18620, 16'sd8060, 16'sd370, -16'sd506};

endpackage

// ==== rtl/cnn_cfg_if.sv ====
`timescale 1ns/10ps

interface cnn_cfg_if;
	import cnn_cfg_pkg::*;
	import cnn_arith_pkg::*;

	dim_t        width;
	dim_t        height;
	act_type_e   act_type;
	bias_shift_t bias_shift;
	act_shift_t  act_shift;
	logic        start;		// One-cycle pulse

	modport regs  (output width, height, act_type, bias_shift, act_shift, start);
	modport scan  (input width, height, start);
	modport fetch (input width, height);
	modport post  (input act_type, bias_shift, act_shift);

endinterface

// ==== rtl/cnn_cfg_pkg.sv ====
`include "cnn_accel_settings.svh"

package cnn_cfg_pkg;

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	typedef enum logic [3:0] {
		REG_DIMS  = 4'd1,	// Width 11:0, height 27:16
		REG_LAYER = 4'd4,	// Act type, bias shift, act shift
		REG_IMAGE = 4'd5,	// Four pixels per word
		REG_START = 4'd8,	// Reads busy
		REG_DONE  = 4'd9
	} cnn_reg_e;

	// AHB-Lite encodings
	typedef enum logic [1:0] {TRANS_IDLE, TRANS_BUSY, TRANS_NONSEQ, TRANS_SEQ} htrans_e;
	localparam logic RESP_OKAY = 1'b0;

	typedef logic [11:0] dim_t;
	typedef logic [$clog2(`CNN_MAX_DIM)-1:0] pos_t;	// Row or column inside the frame
	typedef logic [$clog2(`CNN_MAX_DIM*`CNN_MAX_DIM)-1:0] pix_addr_t;
	typedef logic [$clog2(`CNN_MAX_DIM*`CNN_MAX_DIM*`CNN_PIX_W/`CNN_HDATA_W)-1:0] img_addr_t;
	typedef logic [4:0] bias_shift_t;
	typedef logic [2:0] act_shift_t;

	// Values after reset
	localparam dim_t        RST_DIM        = dim_t'(`CNN_MAX_DIM);
	localparam bias_shift_t RST_BIAS_SHIFT = 5'd9;
	localparam act_shift_t  RST_ACT_SHIFT  = 3'd7;

	// ----------------------------------------
	// Register word views
	// ----------------------------------------
	typedef struct packed {
		logic [3:0]  rsv_hi;
		dim_t        height;
		logic [3:0]  rsv_lo;
		dim_t        width;
	} dims_reg_t;

	typedef struct packed {
		logic [15:0]              rsv_hi;
		act_shift_t               act_shift;	// Bits 15:13
		bias_shift_t              bias_shift;	// Bits 12:8
		logic [3:0]               rsv_mid;
		cnn_arith_pkg::act_type_e act_type;	// Bit 3
		logic [2:0]               rsv_lo;
	} layer_reg_t;

	typedef union packed {
		logic [`CNN_HDATA_W-1:0] raw;
		dims_reg_t               dims;
		layer_reg_t              layer;
	} cnn_reg_word_u;

endpackage

// ==== rtl/conv_mac.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module conv_mac (
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  cnn_arith_pkg::window_t  win_i,
	input  logic                    win_valid_i,
	input  logic                    win_last_i,
	output cnn_arith_pkg::sum_vec_t sum_o,
	output logic                    sum_valid_o,
	output logic                    sum_last_o
);
	import cnn_arith_pkg::*;

	prod_t    prod_q [`CNN_N_CH][`CNN_TAPS];	// 36 products
	sum_vec_t sum_d;
	logic     valid_q;
	logic     last_q;

	// Stage 1, pixel zero-extended so the product stays signed
	always_ff @(posedge HCLK) begin
		if (win_valid_i)
			for (int c = 0; c < `CNN_N_CH; c++)
				for (int t = 0; t < `CNN_TAPS; t++)
					prod_q[c][t] <= $signed({1'b0, win_i[t]}) * $signed(KERN_W[c][t]);
	end

	// Stage 2, adder tree per channel
	always_comb begin
		for (int c = 0; c < `CNN_N_CH; c++) begin
			sum_d[c] = '0;
			for (int t = 0; t < `CNN_TAPS; t++)
				sum_d[c] = sum_d[c] + prod_q[c][t];	// Sign-extended to sum_t
		end
	end

	always_ff @(posedge HCLK) begin
		if (valid_q)
			sum_o <= sum_d;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			valid_q     <= 1'b0;
			last_q      <= 1'b0;
			sum_valid_o <= 1'b0;
			sum_last_o  <= 1'b0;
		end else begin
			valid_q     <= win_valid_i;
			last_q      <= win_valid_i && win_last_i;
			sum_valid_o <= valid_q;
			sum_last_o  <= valid_q && last_q;
		end
	end

endmodule

// ==== rtl/frame_scan.sv ====
`timescale 1ns/10ps

module frame_scan (
	input  logic              HCLK,
	input  logic              HRESETn,
	cnn_cfg_if.scan           cfg,
	output logic              busy_o,
	output cnn_cfg_pkg::pos_t row_o,
	output cnn_cfg_pkg::pos_t col_o,
	output logic              pos_valid_o,
	output logic              pos_last_o
);

	logic last_col;
	logic last_row;

	assign last_col = (col_o == cfg.width - 1'b1);
	assign last_row = (row_o == cfg.height - 1'b1);

	// ----------------------------------------
	// Raster counter, one position per cycle
	// ----------------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			busy_o <= 1'b0;
			row_o  <= '0;
			col_o  <= '0;
		end else if (cfg.start) begin
			busy_o <= 1'b1;		// First position next cycle
			row_o  <= '0;
			col_o  <= '0;
		end else if (busy_o) begin
			if (last_col) begin
				col_o <= '0;
				row_o <= row_o + 1'b1;
				if (last_row)
					busy_o <= 1'b0;	// Frame fully scanned
			end else begin
				col_o <= col_o + 1'b1;
			end
		end
	end

	assign pos_valid_o = busy_o;
	assign pos_last_o  = busy_o && last_col && last_row;

	a_col_in_frame: assert property (@(posedge HCLK) disable iff (!HRESETn)
		pos_valid_o |-> (col_o < cfg.width));

endmodule

// ==== rtl/post_proc.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module post_proc (
	input  logic                    HCLK,
	input  logic                    HRESETn,
	cnn_cfg_if.post                 cfg,
	input  cnn_arith_pkg::sum_vec_t sum_i,
	input  logic                    sum_valid_i,
	input  logic                    sum_last_i,
	output logic [`CNN_HDATA_W-1:0] out_pixel_o,
	output logic                    out_valid_o,
	output logic                    frame_done_o
);
	import cnn_arith_pkg::*;

	acc_t                  t_q [`CNN_N_CH];	// Scaled sum plus shifted bias
	logic [`CNN_PIX_W-1:0] sat_d [`CNN_N_CH];	// Two's complement in linear mode
	logic [5:0]            tot_shift;		// Up to 31 + 7
	logic                  valid_q;
	logic                  last_q;

	assign tot_shift = 6'(cfg.bias_shift) + 6'(cfg.act_shift);

	// Stage 1, scale and bias
	always_ff @(posedge HCLK) begin
		if (sum_valid_i)
			for (int c = 0; c < `CNN_N_CH; c++)
				t_q[c] <= acc_t'($signed(sum_i[c])) * acc_t'(KERN_SCALE[c]) +
					(acc_t'(KERN_BIAS[c]) <<< cfg.bias_shift);
	end

	// ----------------------------------------
	// Stage 2, shift, activation, saturation
	// ----------------------------------------
	always_comb begin
		acc_t u;
		for (int c = 0; c < `CNN_N_CH; c++) begin
			u = t_q[c] >>> tot_shift;
			if (cfg.act_type == ACT_LINEAR)
				sat_d[c] = (u < -128) ? 8'h80 : (u > 127) ? 8'h7f : u[`CNN_PIX_W-1:0];
			else
				sat_d[c] = (u < 0) ? 8'h00 : (u > 255) ? 8'hff : u[`CNN_PIX_W-1:0];
		end
	end

	// Channel 0 in the low byte
	always_ff @(posedge HCLK) begin
		if (valid_q)
			for (int c = 0; c < `CNN_N_CH; c++)
				out_pixel_o[c*`CNN_PIX_W +: `CNN_PIX_W] <= sat_d[c];
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			valid_q      <= 1'b0;
			last_q       <= 1'b0;
			out_valid_o  <= 1'b0;
			frame_done_o <= 1'b0;
		end else begin
			valid_q      <= sum_valid_i;
			last_q       <= sum_valid_i && sum_last_i;
			out_valid_o  <= valid_q;
			frame_done_o <= valid_q && last_q;	// With the last output
		end
	end

	// Negative pre-activation leaves a zero byte in ReLU mode
	for (genvar g = 0; g < `CNN_N_CH; g++) begin : g_relu_chk
		a_relu_nonneg: assert property (@(posedge HCLK) disable iff (!HRESETn)
			(valid_q && cfg.act_type == ACT_RELU && t_q[g] < 0) |=>
			(out_pixel_o[g*`CNN_PIX_W +: `CNN_PIX_W] == '0));
	end

endmodule

// ==== rtl/window_fetch.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module window_fetch (
	input  logic                     HCLK,
	input  logic                     HRESETn,
	cnn_cfg_if.fetch                 cfg,
	input  logic                     img_we_i,
	input  cnn_cfg_pkg::img_addr_t   img_waddr_i,
	input  logic [`CNN_HDATA_W-1:0]  img_wdata_i,
	input  cnn_cfg_pkg::pos_t        row_i,
	input  cnn_cfg_pkg::pos_t        col_i,
	input  logic                     pos_valid_i,
	input  logic                     pos_last_i,
	output cnn_arith_pkg::window_t   win_o,
	output logic                     win_valid_o,
	output logic                     win_last_o
);
	import cnn_cfg_pkg::*;
	import cnn_arith_pkg::*;

	localparam int PIX_PER_WORD = `CNN_HDATA_W / `CNN_PIX_W;

	pixel_t  img_mem [`CNN_MAX_DIM*`CNN_MAX_DIM];	// Raster order, row stride = width
	window_t win_d;

	// Four pixels per bus word, lowest pixel first
	always_ff @(posedge HCLK) begin
		if (img_we_i)
			for (int i = 0; i < PIX_PER_WORD; i++)
				img_mem[pix_addr_t'(PIX_PER_WORD * img_waddr_i + i)] <=
					img_wdata_i[i*`CNN_PIX_W +: `CNN_PIX_W];
	end

	// ----------------------------------------
	// 3x3 neighbours with border zeroing
	// ----------------------------------------
	always_comb begin
		int r;
		int c;
		for (int t = 0; t < `CNN_TAPS; t++) begin
			r = int'(row_i) + t / `CNN_KSIDE - 1;
			c = int'(col_i) + t % `CNN_KSIDE - 1;
			if (r < 0 || c < 0 || r >= int'(cfg.height) || c >= int'(cfg.width))
				win_d[t] = '0;		// Outside the frame
			else
				win_d[t] = img_mem[pix_addr_t'(r * int'(cfg.width) + c)];
		end
	end

	always_ff @(posedge HCLK) begin
		if (pos_valid_i)
			win_o <= win_d;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			win_valid_o <= 1'b0;
			win_last_o  <= 1'b0;
		end else begin
			win_valid_o <= pos_valid_i;
			win_last_o  <= pos_valid_i && pos_last_i;
		end
	end

endmodule

// ==== testbench/tb_cnn_accel.sv ====
`timescale 1ns/10ps
`include "cnn_accel_settings.svh"

module tb_cnn_accel;
	import cnn_cfg_pkg::*;
	import cnn_arith_pkg::*;

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam int N_TESTS       = 5;
	localparam int COLLECT_SLACK = 16;	// Pipeline latency plus margin
	localparam int DONE_POLLS    = 10;

	// One frame per row
	typedef struct packed {
		logic [11:0] width;
		logic [11:0] height;
		logic        act;		// 0 ReLU, 1 linear
		logic [4:0]  bias_shift;
		logic [2:0]  act_shift;
	} test_row_t;

	localparam test_row_t TEST_TABLE [N_TESTS] = '{
		'{12'd16, 12'd16, 1'b0, 5'd9,  3'd7},	// Reset shifts, full frame
		'{12'd16, 12'd16, 1'b1, 5'd9,  3'd5},	// Linear, clamps often
		'{12'd7,  12'd12, 1'b0, 5'd10, 3'd6},
		'{12'd12, 12'd7,  1'b1, 5'd8,  3'd7},
		'{12'd5,  12'd3,  1'b1, 5'd12, 3'd4}	// Tiny frame, mostly border
	};

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL_i;
	logic        HREADY_i;
	logic [1:0]  HTRANS_i;
	logic [31:0] HADDR_i;
	logic        HWRITE_i;
	logic [31:0] HWDATA_i;
	logic        HREADYOUT_o;
	logic        HRESP_o;
	logic [31:0] HRDATA_o;
	logic [31:0] out_pixel_o;
	logic        out_valid_o;

	logic [7:0] img_pix [`CNN_MAX_DIM*`CNN_MAX_DIM];	// Copy of the image buffer
	integer     seed = 17429;
	int         error_count = 0;
	int         test_count = 0;
	int         failed_count = 0;
	bit         timed_out = 1'b0;	// Stops the remaining rows

	cnn_accel UUT (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.HSEL_i      (HSEL_i),
		.HREADY_i    (HREADY_i),
		.HTRANS_i    (HTRANS_i),
		.HADDR_i     (HADDR_i),
		.HWRITE_i    (HWRITE_i),
		.HWDATA_i    (HWDATA_i),
		.HREADYOUT_o (HREADYOUT_o),
		.HRESP_o     (HRESP_o),
		.HRDATA_o    (HRDATA_o),
		.out_pixel_o (out_pixel_o),
		.out_valid_o (out_valid_o)
	);

	always #2 HCLK = ~HCLK;	// 4 ns period

	// ----------------------------------------
	// Checking and reporting
	// ----------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (error_count != errs_before) begin
			failed_count++;
			$display("test %s: %0d errors", name, error_count - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic report_timeout(input string why);
		$display("timeout at %0t ns: %s", $time, why);
		error_count++;
		timed_out = 1'b1;
	endtask

	// ----------------------------------------
	// AHB-Lite master, called on a falling edge
	// ----------------------------------------
	function automatic logic [31:0] reg_addr(input int idx);
		return 32'(idx << `CNN_REG_LSB);
	endfunction

	task automatic check_bus_status();
		check_value("HREADYOUT_o", 32'(HREADYOUT_o), 32'h1);
		check_value("HRESP_o", 32'(HRESP_o), 32'h0);	// OKAY
	endtask

	task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
		HSEL_i   = 1'b1;		// Address phase
		HTRANS_i = HTRANS_NONSEQ;
		HADDR_i  = addr;
		HWRITE_i = 1'b1;
		@(negedge HCLK);
		HSEL_i   = 1'b0;		// Data phase
		HTRANS_i = HTRANS_IDLE;
		HWRITE_i = 1'b0;
		HWDATA_i = data;
		check_bus_status();
		@(negedge HCLK);		// Write taken at the edge in between
	endtask

	task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
		HSEL_i   = 1'b1;
		HTRANS_i = HTRANS_NONSEQ;
		HADDR_i  = addr;
		HWRITE_i = 1'b0;
		@(negedge HCLK);
		HSEL_i   = 1'b0;
		HTRANS_i = HTRANS_IDLE;
		data     = HRDATA_o;	// Mid data phase
		check_bus_status();
	endtask

	// ----------------------------------------
	// Image and reference model
	// ----------------------------------------
	task automatic load_image(input int npix);
		logic [31:0] word;
		for (int i = 0; i < `CNN_MAX_DIM*`CNN_MAX_DIM; i++)
			img_pix[i] = (i < npix) ? 8'($random(seed)) : 8'h00;
		for (int wi = 0; wi < (npix + 3) / 4; wi++) begin
			word = {img_pix[4*wi+3], img_pix[4*wi+2], img_pix[4*wi+1], img_pix[4*wi]};
			ahb_write(32'(wi << `CNN_IMG_LSB) | reg_addr(int'(REG_IMAGE)), word);
		end
	endtask

	function automatic logic [31:0] model_pixel(input int row, input int col,
		input test_row_t tr);
		logic [31:0] word;
		longint s;
		longint t;
		longint u;
		int r;
		int c;
		int p;
		word = '0;
		for (int ch = 0; ch < `CNN_N_CH; ch++) begin
			s = 0;
			for (int k = 0; k < `CNN_TAPS; k++) begin
				r = row + k / 3 - 1;
				c = col + k % 3 - 1;
				if (r < 0 || c < 0 || r >= int'(tr.height) || c >= int'(tr.width))
					p = 0;		// Zero padding
				else
					p = img_pix[r * int'(tr.width) + c];
				s = s + longint'(p) * longint'($signed(KERN_W[ch][k]));
			end
			t = s * longint'($signed(KERN_SCALE[ch])) +
				(longint'($signed(KERN_BIAS[ch])) <<< int'(tr.bias_shift));
			u = t >>> (int'(tr.bias_shift) + int'(tr.act_shift));
			if (tr.act) begin
				if (u < -128)
					u = -128;
				else if (u > 127)
					u = 127;
			end else begin
				if (u < 0)
					u = 0;
				else if (u > 255)
					u = 255;
			end
			word[ch*8 +: 8] = 8'(u);	// Two's complement in linear mode
		end
		return word;
	endfunction

	// ----------------------------------------
	// One table row
	// ----------------------------------------
	task automatic run_frame(input int idx);
		test_row_t   tr;
		string       test_name;
		int          npix;
		int          errs_before;
		int          count;
		int          cycles;
		logic        started;
		logic [31:0] rd;
		tr          = TEST_TABLE[idx];
		errs_before = error_count;
		npix        = int'(tr.width) * int'(tr.height);
		test_name   = $sformatf("frame %0d (%0dx%0d %s, shifts %0d/%0d)", idx, tr.width,
			tr.height, tr.act ? "linear" : "relu", tr.bias_shift, tr.act_shift);
		load_image(npix);
		ahb_write(reg_addr(int'(REG_DIMS)), {4'h0, tr.height, 4'h0, tr.width});
		ahb_write(reg_addr(int'(REG_LAYER)),
			{16'h0, tr.act_shift, tr.bias_shift, 4'h0, tr.act, 3'h0});
		ahb_read(reg_addr(int'(REG_DIMS)), rd);
		check_value("REG_DIMS", rd, {4'h0, tr.height, 4'h0, tr.width});
		ahb_read(reg_addr(int'(REG_LAYER)), rd);
		check_value("REG_LAYER", rd, {16'h0, tr.act_shift, tr.bias_shift, 4'h0, tr.act, 3'h0});

		ahb_write(reg_addr(int'(REG_START)), 32'h1);
		ahb_read(reg_addr(int'(REG_DONE)), rd);	// Cleared by start
		check_value("REG_DONE", rd, 32'h0);
		ahb_read(reg_addr(int'(REG_START)), rd);	// Busy
		check_value("REG_START", rd, 32'h1);

		// Stream must be one unbroken burst in raster order
		count   = 0;
		cycles  = 0;
		started = 1'b0;
		while (count < npix && !timed_out) begin
			@(negedge HCLK);
			cycles++;
			if (cycles > npix + COLLECT_SLACK) begin
				report_timeout("output pixels stopped before the frame was complete");
			end else if (out_valid_o === 1'b1) begin
				check_value($sformatf("out_pixel_o[%0d]", count), out_pixel_o,
					model_pixel(count / int'(tr.width), count % int'(tr.width), tr));
				count++;
				started = 1'b1;
			end else if (started) begin
				check_value("out_valid_o", 32'(out_valid_o), 32'h1);	// Gap
			end
		end
		if (timed_out) begin
			report_test(test_name, errs_before);
			return;
		end
		@(negedge HCLK);
		check_value("out_valid_o", 32'(out_valid_o), 32'h0);	// No extra pixel

		cycles = 0;
		rd     = '0;
		while (rd[0] !== 1'b1 && !timed_out) begin
			if (cycles >= DONE_POLLS) begin
				report_timeout("REG_DONE never went high after the frame");
			end else begin
				ahb_read(reg_addr(int'(REG_DONE)), rd);
				cycles++;
			end
		end
		if (timed_out) begin
			report_test(test_name, errs_before);
			return;
		end
		ahb_read(reg_addr(int'(REG_START)), rd);
		check_value("REG_START", rd, 32'h0);	// Idle again

		// Odd rows leave done set so the next start clears it
		if (idx % 2 == 0) begin
			ahb_write(reg_addr(int'(REG_DONE)), 32'h0);
			ahb_read(reg_addr(int'(REG_DONE)), rd);
			check_value("REG_DONE", rd, 32'h0);
		end
		report_test(test_name, errs_before);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		logic [31:0] rd;
		int          errs_before;
		HCLK     = 1'b0;
		HRESETn  = 1'b0;
		HSEL_i   = 1'b0;
		HREADY_i = 1'b1;
		HTRANS_i = HTRANS_IDLE;
		HADDR_i  = '0;
		HWRITE_i = 1'b0;
		HWDATA_i = '0;
		repeat (16) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
		@(negedge HCLK);

		errs_before = error_count;
		ahb_read(reg_addr(int'(REG_DIMS)), rd);
		check_value("REG_DIMS", rd, {4'h0, 12'd16, 4'h0, 12'd16});
		ahb_read(reg_addr(int'(REG_LAYER)), rd);
		check_value("REG_LAYER", rd, {16'h0, 3'd7, 5'd9, 4'h0, 1'b0, 3'h0});
		ahb_read(reg_addr(int'(REG_START)), rd);
		check_value("REG_START", rd, 32'h0);
		ahb_read(reg_addr(int'(REG_DONE)), rd);
		check_value("REG_DONE", rd, 32'h0);
		check_value("out_valid_o", 32'(out_valid_o), 32'h0);
		report_test("reset values", errs_before);

		for (int i = 0; i < N_TESTS && !timed_out; i++)
			run_frame(i);

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_count,
			error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
